//--- sd_reader_config.svh
//********************************************************************
// compile-time timing for the sd reader, no runtime configuration
// SD_SIM set to 1 shortens init for simulation, set 0 for a real card
//********************************************************************
`ifndef SD_READER_CONFIG_SVH
`define SD_READER_CONFIG_SVH

// simulation shortening flag
`define SD_SIM 1

// system clocks per spi half period, slow one must give <= 400 khz
`define SD_CLK_DIV_SLOW ((`SD_SIM) ? 4 : 63)
`define SD_CLK_DIV_FAST 2

// idle clocks with cs high before cmd0, multiple of 8
`define SD_INIT_CLOCKS 80
// acmd41 loop bound, counter is 12 bits
`define SD_ACMD41_TRIES ((`SD_SIM) ? 16 : 2000)
// bytes polled for r1 or data token, counter is 10 bits
`define SD_RESP_WAIT 1000
`define SD_SECTOR_BYTES 512

`endif

//--- sd_reader_pkg.sv
//********************************************************************
// shared types of the sd sector reader
//********************************************************************
package sd_reader_pkg;

  // host command on the top level port
  typedef enum logic [1:0] {
    CMD_IDLE = 2'd0,
    CMD_READ = 2'd1,
    CMD_NEXT = 2'd2
  } host_cmd_e;

  typedef enum logic [1:0] {
    TYPE_UNKNOWN = 2'd0,
    TYPE_SDV1    = 2'd1,
    TYPE_SDV2    = 2'd2,
    TYPE_SDHC    = 2'd3
  } card_type_e;

  // controller state, also shown on card_stat
  typedef enum logic [3:0] {
    ST_RESET,
    ST_INIT_CLKS,
    ST_CMD0,
    ST_CMD8,
    ST_CMD55,
    ST_ACMD41,
    ST_CMD58,
    ST_IDLE,
    ST_CMD17,
    ST_TOKEN,
    ST_DATA,
    ST_CRC,
    ST_ERROR
  } ctrl_state_e;

  // step inside one command exchange
  typedef enum logic [1:0] {PH_FRAME, PH_POLL, PH_TAIL} cmd_phase_e;

  // sector buffer states
  typedef enum logic [1:0] {BUF_INIT, BUF_IDLE, BUF_READ} buf_state_e;

endpackage

//--- sd_if.sv
//********************************************************************
// internal links: controller to spi engine, buffer to controller
// start may only come while the engine is not shifting
//********************************************************************
`timescale 1ns/1ns

// byte level spi link
interface sd_spi_if;
  logic       start;
  logic [7:0] tx_byte;
  logic       fast;
  logic       cs_n;
  logic [7:0] rx_byte;
  logic       done;

  modport controller (output start, tx_byte, fast, cs_n, input rx_byte, done);
  modport engine (input start, tx_byte, fast, cs_n, output rx_byte, done);
endinterface

// sector read request and byte stream
interface sd_read_if;
  logic        rstart;
  logic [31:0] rsector;
  logic        rbusy;
  logic        rdone;
  logic        outen;
  logic [8:0]  outaddr;
  logic [7:0]  outbyte;

  modport buffer (
    output rstart, rsector,
    input  rbusy, rdone, outen, outaddr, outbyte
  );
  modport controller (
    input  rstart, rsector,
    output rbusy, rdone, outen, outaddr, outbyte
  );
endinterface

//--- sd_spi_engine.sv
//********************************************************************
// spi mode 0 byte shifter, msb first, sd_clk idles low
// keeps clocking with cs_n high, the controller uses this for init
//********************************************************************
`timescale 1ns/1ns
`include "sd_reader_config.svh"

module sd_spi_engine (
  input  logic     clk,
  input  logic     rst_n,
  sd_spi_if.engine spi,
  output logic     sd_clk,
  output logic     sd_mosi,
  input  logic     sd_miso,
  output logic     sd_cs_n
);

  localparam logic [15:0] div_slow = 16'(`SD_CLK_DIV_SLOW - 1);
  localparam logic [15:0] div_fast = 16'(`SD_CLK_DIV_FAST - 1);

  logic        active;
  logic        last;
  logic [15:0] div_cnt;
  logic [15:0] div_load;
  logic [2:0]  bit_cnt;
  logic [7:0]  tx_sr;
  logic [7:0]  rx_sr;
  logic        tick;

  assign div_load    = spi.fast ? div_fast : div_slow;
  // half period boundary while a byte is in flight
  assign tick        = active && (div_cnt == 16'd0);
  assign sd_mosi     = tx_sr[7];
  assign sd_cs_n     = spi.cs_n;
  assign spi.rx_byte = rx_sr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active   <= 1'b0;
      last     <= 1'b0;
      spi.done <= 1'b0;
      div_cnt  <= 16'd0;
      bit_cnt  <= 3'd0;
      sd_clk   <= 1'b0;
      tx_sr    <= 8'hFF;
    end else begin
      // done trails the last falling edge by one cycle
      spi.done <= last;
      last     <= 1'b0;
      if (spi.start) begin
        active  <= 1'b1;
        div_cnt <= div_load;
        bit_cnt <= 3'd0;
        tx_sr   <= spi.tx_byte;
      end else if (tick) begin
        div_cnt <= div_load;
        sd_clk  <= ~sd_clk;
        // falling edge: next bit out, line idles high after the byte
        if (sd_clk) begin
          tx_sr   <= {tx_sr[6:0], 1'b1};
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            active <= 1'b0;
            last   <= 1'b1;
          end
        end
      end else if (active) begin
        div_cnt <= div_cnt - 16'd1;
      end
    end
  end

  // sample miso on the rising edge
  always_ff @(posedge clk) begin
    if (tick && !sd_clk) begin
      rx_sr <= {rx_sr[6:0], sd_miso};
    end
  end

endmodule

//--- sd_card_ctrl.sv
//********************************************************************
// sd init (cmd0, cmd8, acmd41, cmd58) and cmd17 single sector read
// no crc check, no retry: any card error parks in ST_ERROR, rbusy high
//********************************************************************
`timescale 1ns/1ns
`include "sd_reader_config.svh"

module sd_card_ctrl import sd_reader_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  sd_spi_if.controller spi,
  sd_read_if.controller rd,
  output logic [3:0]   card_stat,
  output card_type_e   card_type
);

  localparam logic [9:0]  init_last   = 10'(`SD_INIT_CLOCKS / 8 - 1);
  localparam logic [9:0]  resp_last   = 10'(`SD_RESP_WAIT - 1);
  localparam logic [9:0]  sector_last = 10'(`SD_SECTOR_BYTES - 1);
  localparam logic [11:0] tries_last  = 12'(`SD_ACMD41_TRIES - 1);

  ctrl_state_e state;
  cmd_phase_e  phase;
  card_type_e  ctype;
  logic        pend;
  logic        v2;
  logic [9:0]  cnt;
  logic [11:0] tries;
  logic [23:0] tail;
  logic [5:0]  cmd_idx;
  logic [31:0] cmd_arg;
  logic [7:0]  cmd_crc;
  logic [7:0]  frame;
  logic [7:0]  tx_next;
  logic        in_cmd;

  assign card_stat = state;
  assign card_type = ctype;
  assign in_cmd    = state inside {ST_CMD0, ST_CMD8, ST_CMD55, ST_ACMD41, ST_CMD58, ST_CMD17};

  // command frame of the current state
  always_comb begin
    cmd_idx = 6'd0;
    cmd_arg = 32'd0;
    cmd_crc = 8'h01;
    case (state)
      ST_CMD0: cmd_crc = 8'h95;
      ST_CMD8: begin
        cmd_idx = 6'd8;
        cmd_arg = 32'h0000_01AA;
        cmd_crc = 8'h87;
      end
      ST_CMD55: cmd_idx = 6'd55;
      ST_ACMD41: begin
        cmd_idx = 6'd41;
        // hcs bit only for v2 cards
        cmd_arg = {1'b0, v2, 30'd0};
      end
      ST_CMD58: cmd_idx = 6'd58;
      ST_CMD17: begin
        cmd_idx = 6'd17;
        // byte address unless high capacity
        cmd_arg = (ctype == TYPE_SDHC) ? rd.rsector : {rd.rsector[22:0], 9'd0};
      end
      default: cmd_idx = 6'd0;
    endcase
    case (cnt[2:0])
      3'd0:    frame = {2'b01, cmd_idx};
      3'd1:    frame = cmd_arg[31:24];
      3'd2:    frame = cmd_arg[23:16];
      3'd3:    frame = cmd_arg[15:8];
      3'd4:    frame = cmd_arg[7:0];
      default: frame = cmd_crc;
    endcase
    tx_next = (in_cmd && phase == PH_FRAME) ? frame : 8'hFF;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_RESET;
      phase     <= PH_FRAME;
      ctype     <= TYPE_UNKNOWN;
      pend      <= 1'b0;
      v2        <= 1'b0;
      cnt       <= 10'd0;
      tries     <= 12'd0;
      spi.start <= 1'b0;
      spi.fast  <= 1'b0;
      spi.cs_n  <= 1'b1;
      rd.rbusy  <= 1'b1;
      rd.rdone  <= 1'b0;
      rd.outen  <= 1'b0;
    end else begin
      spi.start <= 1'b0;
      rd.rdone  <= 1'b0;
      rd.outen  <= 1'b0;
      case (state)
        ST_RESET: state <= ST_INIT_CLKS;
        ST_IDLE: begin
          if (rd.rstart) begin
            state    <= ST_CMD17;
            phase    <= PH_FRAME;
            cnt      <= 10'd0;
            rd.rbusy <= 1'b1;
          end
        end
        ST_ERROR: state <= ST_ERROR;
        default: begin
          // one byte in flight at a time, next start after done
          if (!pend) begin
            spi.start   <= 1'b1;
            spi.tx_byte <= tx_next;
            pend        <= 1'b1;
          end else if (spi.done) begin
            pend <= 1'b0;
            cnt  <= cnt + 10'd1;
            case (state)
              ST_INIT_CLKS: begin
                if (cnt == init_last) begin
                  state    <= ST_CMD0;
                  cnt      <= 10'd0;
                  spi.cs_n <= 1'b0;
                end
              end
              ST_TOKEN: begin
                if (spi.rx_byte == 8'hFE) begin
                  state <= ST_DATA;
                  cnt   <= 10'd0;
                end else if (spi.rx_byte != 8'hFF || cnt == resp_last) begin
                  state <= ST_ERROR;
                end
              end
              ST_DATA: begin
                rd.outen   <= 1'b1;
                rd.outaddr <= cnt[8:0];
                rd.outbyte <= spi.rx_byte;
                if (cnt == sector_last) begin
                  state <= ST_CRC;
                  cnt   <= 10'd0;
                end
              end
              ST_CRC: begin
                // both crc bytes dropped
                if (cnt[0]) begin
                  state    <= ST_IDLE;
                  rd.rdone <= 1'b1;
                  rd.rbusy <= 1'b0;
                end
              end
              default: begin
                if (phase == PH_FRAME) begin
                  if (cnt == 10'd5) begin
                    phase <= PH_POLL;
                    cnt   <= 10'd0;
                  end
                end else if (phase == PH_POLL) begin
                  if (spi.rx_byte == 8'hFF) begin
                    if (cnt == resp_last) state <= ST_ERROR;
                  end else begin
                    // r1 arrived
                    cnt   <= 10'd0;
                    phase <= PH_FRAME;
                    case (state)
                      ST_CMD0: state <= (spi.rx_byte == 8'h01) ? ST_CMD8 : ST_ERROR;
                      ST_CMD8: begin
                        // illegal command means a v1 card
                        if (spi.rx_byte[2]) state <= ST_CMD55;
                        else if (spi.rx_byte == 8'h01) phase <= PH_TAIL;
                        else state <= ST_ERROR;
                      end
                      ST_CMD55: state <= (spi.rx_byte[7:1] == 7'd0) ? ST_ACMD41 : ST_ERROR;
                      ST_ACMD41: begin
                        if (spi.rx_byte == 8'h00) begin
                          state <= ST_CMD58;
                        end else if (spi.rx_byte != 8'h01 || tries == tries_last) begin
                          state <= ST_ERROR;
                        end else begin
                          tries <= tries + 12'd1;
                          state <= ST_CMD55;
                        end
                      end
                      ST_CMD58: begin
                        if (spi.rx_byte == 8'h00) phase <= PH_TAIL;
                        else state <= ST_ERROR;
                      end
                      ST_CMD17: state <= (spi.rx_byte == 8'h00) ? ST_TOKEN : ST_ERROR;
                      default: state <= ST_ERROR;
                    endcase
                  end
                end else begin
                  // four trailing bytes of r7 or r3
                  tail <= {tail[15:0], spi.rx_byte};
                  if (cnt == 10'd3) begin
                    cnt   <= 10'd0;
                    phase <= PH_FRAME;
                    if (state == ST_CMD8) begin
                      // voltage accepted and check pattern echoed
                      if ({tail[3:0], spi.rx_byte} == 12'h1AA) begin
                        v2    <= 1'b1;
                        state <= ST_CMD55;
                      end else begin
                        state <= ST_ERROR;
                      end
                    end else begin
                      // ocr bit 30 is ccs
                      if (tail[22]) ctype <= TYPE_SDHC;
                      else ctype <= v2 ? TYPE_SDV2 : TYPE_SDV1;
                      state    <= ST_IDLE;
                      spi.fast <= 1'b1;
                      rd.rbusy <= 1'b0;
                    end
                  end
                end
              end
            endcase
          end
        end
      endcase
    end
  end

endmodule

//--- sd_sector_buffer.sv
//********************************************************************
// host side: command decode, 512 byte sector store, output index
// commands are ignored while busy, data_out reads 0 before any read
//********************************************************************
`timescale 1ns/1ns
`include "sd_reader_config.svh"

module sd_sector_buffer import sd_reader_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  host_cmd_e    command,
  input  logic [31:0]  sector_address,
  output logic [7:0]   data_out,
  output logic         busy,
  sd_read_if.buffer    rd
);

  logic [7:0] mem [`SD_SECTOR_BYTES];
  logic [8:0] index;
  logic       filled;
  buf_state_e state;

  // byte under the index, shown once a sector has been stored
  assign data_out = filled ? mem[index] : 8'h00;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= BUF_INIT;
      busy      <= 1'b1;
      rd.rstart <= 1'b0;
      index     <= 9'd0;
      filled    <= 1'b0;
    end else begin
      rd.rstart <= 1'b0;
      case (state)
        // wait for card init to finish
        BUF_INIT: begin
          if (!rd.rbusy) begin
            busy  <= 1'b0;
            state <= BUF_IDLE;
          end
        end
        BUF_IDLE: begin
          if (command == CMD_READ) begin
            rd.rsector <= sector_address;
            rd.rstart  <= 1'b1;
            // byte 0 is ready when busy drops
            index      <= 9'd0;
            busy       <= 1'b1;
            state      <= BUF_READ;
          end else if (command == CMD_NEXT) begin
            // wraps 511 to 0
            index <= index + 9'd1;
          end
        end
        BUF_READ: begin
          if (rd.rdone) begin
            busy   <= 1'b0;
            filled <= 1'b1;
            state  <= BUF_IDLE;
          end
        end
        default: state <= BUF_INIT;
      endcase
    end
  end

  // bytes land as they come from the card, no back-pressure
  always_ff @(posedge clk) begin
    if (rd.outen) begin
      mem[rd.outaddr] <= rd.outbyte;
    end
  end

endmodule

//--- sd_reader_top.sv
//********************************************************************
// sd card sector reader, spi mode, single 512 byte block reads
// host steps through the stored sector one byte per CMD_NEXT
//********************************************************************
`timescale 1ns/1ns

module sd_reader_top import sd_reader_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  host_cmd_e   command,
  input  logic [31:0] sector_address,
  output logic [7:0]  data_out,
  output logic        busy,
  output logic [3:0]  card_stat,
  output card_type_e  card_type,
  output logic        sd_cs_n,
  output logic        sd_clk,
  output logic        sd_mosi,
  input  logic        sd_miso
);

  // controller to spi engine
  sd_spi_if  spi_bus ();
  // buffer to controller
  sd_read_if rd_bus ();

  sd_sector_buffer buffer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .command        (command),
    .sector_address (sector_address),
    .data_out       (data_out),
    .busy           (busy),
    .rd             (rd_bus.buffer)
  );

  sd_card_ctrl ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi       (spi_bus.controller),
    .rd        (rd_bus.controller),
    .card_stat (card_stat),
    .card_type (card_type)
  );

  sd_spi_engine engine_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .spi     (spi_bus.engine),
    .sd_clk  (sd_clk),
    .sd_mosi (sd_mosi),
    .sd_miso (sd_miso),
    .sd_cs_n (sd_cs_n)
  );

endmodule

//--- sd_card_model.sv
//********************************************************************
// behavioral spi mode sdhc card, answers init and cmd17 only
// byte i of sector s is i plus the xor of the four bytes of s
//********************************************************************
`timescale 1ns/1ns

module sd_card_model (
  input  logic sd_cs_n,
  input  logic sd_clk,
  input  logic sd_mosi,
  output logic sd_miso
);

  logic [7:0] rx_sr;
  logic [2:0] in_cnt;
  logic [7:0] out_sr;
  logic [2:0] out_cnt;
  logic [7:0] frame [6];
  logic [2:0] frame_len;
  logic       app_cmd;
  int         acmd41_count;
  // bytes waiting to go out on miso
  logic [7:0] resp_q [$];

  // miso floats high while deselected
  assign sd_miso = sd_cs_n ? 1'b1 : out_sr[7];

  initial begin
    rx_sr        = 8'hFF;
    in_cnt       = 3'd0;
    out_sr       = 8'hFF;
    out_cnt      = 3'd0;
    frame_len    = 3'd0;
    app_cmd      = 1'b0;
    acmd41_count = 0;
  end

  task automatic respond();
    logic [5:0]  idx;
    logic [31:0] arg;
    logic [7:0]  xs;
    idx = frame[0][5:0];
    arg = {frame[1], frame[2], frame[3], frame[4]};
    xs  = arg[31:24] ^ arg[23:16] ^ arg[15:8] ^ arg[7:0];
    // one byte of ncr before each response
    resp_q.push_back(8'hFF);
    if (app_cmd && idx == 6'd41) begin
      // idle for the first two polls, then ready
      resp_q.push_back((acmd41_count < 2) ? 8'h01 : 8'h00);
      acmd41_count++;
    end else begin
      case (idx)
        6'd0: resp_q.push_back(8'h01);
        6'd8: begin
          // r7 echoes voltage and check pattern
          resp_q.push_back(8'h01);
          resp_q.push_back(8'h00);
          resp_q.push_back(8'h00);
          resp_q.push_back({4'h0, arg[11:8]});
          resp_q.push_back(arg[7:0]);
        end
        6'd55: resp_q.push_back((acmd41_count > 2) ? 8'h00 : 8'h01);
        6'd58: begin
          // ocr with power up and ccs set
          resp_q.push_back(8'h00);
          resp_q.push_back(8'hC0);
          resp_q.push_back(8'hFF);
          resp_q.push_back(8'h80);
          resp_q.push_back(8'h00);
        end
        6'd17: begin
          // sdhc: argument is the sector number itself
          resp_q.push_back(8'h00);
          resp_q.push_back(8'hFF);
          resp_q.push_back(8'hFE);
          for (int i = 0; i < 512; i++) begin
            resp_q.push_back(8'(i) + xs);
          end
          resp_q.push_back(8'h5A);
          resp_q.push_back(8'hA5);
        end
        // illegal command
        default: resp_q.push_back(8'h04);
      endcase
    end
    app_cmd = (idx == 6'd55);
  endtask

  // frames start with 01 in the top bits, filler bytes are skipped
  task automatic take_byte(input logic [7:0] b);
    if (frame_len != 3'd0 || b[7:6] == 2'b01) begin
      frame[frame_len] = b;
      frame_len = frame_len + 3'd1;
      if (frame_len == 3'd6) begin
        respond();
        frame_len = 3'd0;
      end
    end
  endtask

  // host data sampled on the rising edge
  always @(posedge sd_clk) begin
    logic [7:0] b;
    if (!sd_cs_n) begin
      b = {rx_sr[6:0], sd_mosi};
      rx_sr = b;
      if (in_cnt == 3'd7) take_byte(b);
      in_cnt = in_cnt + 3'd1;
    end
  end

  // card data changes on the falling edge, next byte after the 8th
  always @(negedge sd_clk) begin
    if (!sd_cs_n) begin
      if (out_cnt == 3'd7) begin
        if (resp_q.size() > 0) out_sr = resp_q.pop_front();
        else out_sr = 8'hFF;
      end else begin
        out_sr = {out_sr[6:0], 1'b1};
      end
      out_cnt = out_cnt + 3'd1;
    end
  end

endmodule

//--- sd_reader_asserts.sv
//********************************************************************
// protocol checks on the reader top level, attached by bind
//********************************************************************
`timescale 1ns/1ns

module sd_reader_asserts import sd_reader_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       sd_cs_n,
  input logic       busy,
  input logic [3:0] card_stat,
  input logic [7:0] data_out
);

  // card stays deselected while reset is held
  cs_in_reset: assert property (@(posedge clk) !rst_n |=> sd_cs_n)
    else $error("sd_cs_n went low during reset");

  // host sees busy whenever the controller is away from idle
  busy_until_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (card_stat != ST_IDLE) |-> busy)
    else $error("busy low while the controller is not idle");

  data_known: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !$isunknown(data_out))
    else $error("data_out unknown while not busy");

endmodule

bind sd_reader_top sd_reader_asserts asserts_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .sd_cs_n   (sd_cs_n),
  .busy      (busy),
  .card_stat (card_stat),
  .data_out  (data_out)
);

//--- sd_reader_tb.sv
//********************************************************************
// reader testbench, reads come from sd_reader_testdata.txt
// card model answers as sdhc, so sector numbers pass unscaled
//********************************************************************
`timescale 1ns/1ns
`include "sd_reader_config.svh"

module sd_reader_tb import sd_reader_pkg::*; ();

  // rough cycle costs per spi byte, used for timeouts
  localparam int slow_byte   = 16 * `SD_CLK_DIV_SLOW + 4;
  localparam int fast_byte   = 16 * `SD_CLK_DIV_FAST + 4;
  localparam int init_bytes  = 120;
  localparam int read_bytes  = 540;
  localparam int step_cycles = 6 * 700;
  localparam int init_limit  = 2 * init_bytes * slow_byte;
  localparam int read_limit  = 2 * read_bytes * fast_byte;

  logic        clk = 1'b0;
  logic        rst_n;
  host_cmd_e   command;
  logic [31:0] sector_address;
  logic [7:0]  data_out;
  logic        busy;
  logic [3:0]  card_stat;
  card_type_e  card_type;
  logic        sd_cs_n;
  logic        sd_clk;
  logic        sd_mosi;
  logic        sd_miso;

  int          errors;
  int          checks;
  logic [31:0] rng;
  logic        loaded;
  // one entry per data file line
  logic [31:0] rd_sector [$];
  logic [7:0]  rd_first [$];
  logic [31:0] rd_sum [$];
  int          rd_steps [$];

  always #2 clk = ~clk;

  sd_reader_top sd_reader_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .command        (command),
    .sector_address (sector_address),
    .data_out       (data_out),
    .busy           (busy),
    .card_stat      (card_stat),
    .card_type      (card_type),
    .sd_cs_n        (sd_cs_n),
    .sd_clk         (sd_clk),
    .sd_mosi        (sd_mosi),
    .sd_miso        (sd_miso)
  );

  sd_card_model card_inst (
    .sd_cs_n (sd_cs_n),
    .sd_clk  (sd_clk),
    .sd_mosi (sd_mosi),
    .sd_miso (sd_miso)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte i of sector s: i plus xor of the sector bytes
  function automatic logic [7:0] expected_byte(input logic [31:0] s, input int i);
    return 8'(i) + (s[31:24] ^ s[23:16] ^ s[15:8] ^ s[7:0]);
  endfunction

  // inputs change and outputs are read 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("FAILED at %0t ns: %s", $time, what);
    end
  endtask

  task automatic expect_byte(input logic [7:0] exp, input string what);
    checks++;
    assert (data_out === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s, data_out %02h, expected %02h",
               $time, what, data_out, exp);
    end
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (busy !== 1'b0 && n < limit) begin
      next_cycle();
      n++;
    end
    assert (busy === 1'b0) else begin
      errors++;
      $display("busy did not fall within %0d cycles at %0t ns", limit, $time);
    end
  endtask

  task automatic start_read(input logic [31:0] s);
    command        = CMD_READ;
    sector_address = s;
    next_cycle();
    command = CMD_IDLE;
    check(busy === 1'b1, "busy did not rise after CMD_READ");
  endtask

  // one CMD_NEXT, then a random idle gap of 0 to 3 cycles
  task automatic step_next();
    command = CMD_NEXT;
    next_cycle();
    command = CMD_IDLE;
    rng = xorshift(rng);
    repeat (rng[1:0]) next_cycle();
  endtask

  task automatic run_read(input logic [31:0] s, input logic [7:0] first,
                          input logic [31:0] sum, input int steps);
    logic [31:0] total;
    total = 32'd0;
    start_read(s);
    wait_ready(read_limit);
    expect_byte(first, "first byte differs from test data");
    for (int k = 0; k < steps; k++) begin
      expect_byte(expected_byte(s, k % `SD_SECTOR_BYTES), "sector byte");
      if (k < `SD_SECTOR_BYTES) total = total + {24'd0, data_out};
      step_next();
    end
    // 512 steps wrap the index back to byte 0
    expect_byte(expected_byte(s, steps % `SD_SECTOR_BYTES), "byte after stepping");
    if (steps >= `SD_SECTOR_BYTES) begin
      check(total == sum, "sector sum differs from test data");
    end
  endtask

  // commands given while busy must not disturb the running read
  task automatic busy_commands_ignored();
    start_read(32'h1234_5678);
    command = CMD_NEXT;
    next_cycle();
    command        = CMD_READ;
    sector_address = 32'h0000_0001;
    next_cycle();
    command = CMD_IDLE;
    wait_ready(read_limit);
    expect_byte(expected_byte(32'h1234_5678, 0), "byte 0 after commands while busy");
    step_next();
    expect_byte(expected_byte(32'h1234_5678, 1), "byte 1 after commands while busy");
    check(card_stat == ST_IDLE, "controller not idle after read");
  endtask

  task automatic load_testdata();
    int          fd;
    string       line;
    logic [31:0] s;
    logic [31:0] f;
    logic [31:0] sum;
    int          steps;
    fd = $fopen("sd_reader_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open sd_reader_testdata.txt");
    end else begin
      // comment lines give no match and are skipped
      while ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%h %h %h %d", s, f, sum, steps) == 4) begin
          rd_sector.push_back(s);
          rd_first.push_back(f[7:0]);
          rd_sum.push_back(sum);
          rd_steps.push_back(steps);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int limit_cycles;
    wait (loaded === 1'b1);
    limit_cycles = 2 * (init_bytes * slow_byte
                 + (rd_sector.size() + 2) * (read_bytes * fast_byte + step_cycles));
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", limit_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    errors         = 0;
    checks         = 0;
    rng            = 32'h182e;
    loaded         = 1'b0;
    rst_n          = 1'b0;
    command        = CMD_IDLE;
    sector_address = 32'd0;
    load_testdata();
    loaded = 1'b1;
    check(rd_sector.size() > 0, "no reads found in test data");
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check(busy === 1'b1 && sd_cs_n === 1'b1 && sd_clk === 1'b0, "wrong levels after reset");
    // card init, then the card type report
    wait_ready(init_limit);
    check(card_type == TYPE_SDHC, "card type is not SDHC");
    check(card_stat == ST_IDLE, "controller not idle after init");
    for (int r = 0; r < rd_sector.size(); r++) begin
      run_read(rd_sector[r], rd_first[r], rd_sum[r], rd_steps[r]);
    end
    busy_commands_ignored();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sd_reader_testdata.txt
# sector address (hex), first byte (hex), sum of all 512 bytes (hex), next-byte steps (decimal)
# byte i of sector s is the low byte of i plus the xor of the four bytes of s
00000000 00 0000ff00 512
ffffffff 00 0000ff00 512
12345678 08 0000ff00 600
00000001 01 0000ff00 512
deadbeef 22 0000ff00 700
80000000 80 0000ff00 512
0000a5c3 66 0000ff00 530

//--- sd_reader.f
+incdir+.
sd_reader_pkg.sv
sd_if.sv
sd_spi_engine.sv
sd_card_ctrl.sv
sd_sector_buffer.sv
sd_reader_top.sv
sd_card_model.sv
sd_reader_asserts.sv
sd_reader_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sd reader testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sd_reader.f \
  --top-module sd_reader_tb -o sd_reader_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sd_reader_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
